//--- common/viterbi_pkg.sv
package viterbi_pkg;

    //////////////////////////////////////////////////
    // Code and decoder dimensions
    //////////////////////////////////////////////////

    // Rate 1/2, K = 3, generators 7 and 5 (octal)
    localparam int NUM_STATES   = 4;
    localparam int STATE_W      = 2;

    // Survivor history depth in symbols
    localparam int TB_DEPTH     = 12;

    // Symbols accepted before the first decoded bit
    localparam int WARMUP_LEN   = TB_DEPTH - 1;
    localparam int WARMUP_CNT_W = $clog2(TB_DEPTH);

    localparam int BM_W         = 2;
    localparam int PM_W         = 6;

    // Reset metric of every state other than state 0
    localparam int START_METRIC = 16;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // Bit 1 from generator 7, bit 0 from generator 5
    typedef logic [1:0]              symbol_t;

    // Bit 1 is the newest information bit
    typedef logic [STATE_W-1:0]      state_t;

    typedef logic [BM_W-1:0]         branch_metric_t;
    typedef logic [PM_W-1:0]         path_metric_t;

    // One survivor bit per state
    typedef logic [NUM_STATES-1:0]   decision_t;

    typedef logic [WARMUP_CNT_W-1:0] warmup_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        WARMUP,
        DECODE
    } ctrl_state_t;

endpackage

//--- hw/branch_metric.sv
`timescale 1ns/1ns

module branch_metric (
    input  viterbi_pkg::symbol_t        in_symbol,
    output viterbi_pkg::branch_metric_t bm_00,
    output viterbi_pkg::branch_metric_t bm_01,
    output viterbi_pkg::branch_metric_t bm_10,
    output viterbi_pkg::branch_metric_t bm_11
);

    // Number of differing bits between two code pairs
    function automatic viterbi_pkg::branch_metric_t hamming(
        input viterbi_pkg::symbol_t rx,
        input viterbi_pkg::symbol_t code
    );
        viterbi_pkg::symbol_t diff;
        diff = rx ^ code;
        return viterbi_pkg::branch_metric_t'(diff[1]) +
               viterbi_pkg::branch_metric_t'(diff[0]);
    endfunction

    // One distance per possible code pair, shared by all butterflies
    assign bm_00 = hamming(in_symbol, 2'b00);
    assign bm_01 = hamming(in_symbol, 2'b01);
    assign bm_10 = hamming(in_symbol, 2'b10);
    assign bm_11 = hamming(in_symbol, 2'b11);

endmodule

//--- acs/acs_unit.sv
`timescale 1ns/1ns

module acs_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        acs_en,
    input  viterbi_pkg::branch_metric_t bm_00,
    input  viterbi_pkg::branch_metric_t bm_01,
    input  viterbi_pkg::branch_metric_t bm_10,
    input  viterbi_pkg::branch_metric_t bm_11,
    output viterbi_pkg::decision_t      decisions,
    output viterbi_pkg::state_t         best_state
);

    viterbi_pkg::path_metric_t   pm      [0:viterbi_pkg::NUM_STATES-1];
    viterbi_pkg::path_metric_t   pm_next [0:viterbi_pkg::NUM_STATES-1];
    viterbi_pkg::path_metric_t   min_pm;
    viterbi_pkg::branch_metric_t bm_tab  [0:3];

    // Indexed by the expected code pair
    assign bm_tab[0] = bm_00;
    assign bm_tab[1] = bm_01;
    assign bm_tab[2] = bm_10;
    assign bm_tab[3] = bm_11;

    // Minimum of the registered metrics, lowest state wins a tie
    always_comb begin
        min_pm     = pm[0];
        best_state = '0;
        for (int s = 1; s < viterbi_pkg::NUM_STATES; s++) begin
            if (pm[s] < min_pm) begin
                min_pm     = pm[s];
                best_state = viterbi_pkg::state_t'(s);
            end
        end
    end

    //////////////////////////////////////////////////
    // Add-compare-select
    //////////////////////////////////////////////////

    // Predecessor of state s with decision d is {s[0], d}
    always_comb begin
        viterbi_pkg::state_t       st;
        viterbi_pkg::symbol_t      pair0;
        viterbi_pkg::path_metric_t cand0;
        viterbi_pkg::path_metric_t cand1;
        for (int s = 0; s < viterbi_pkg::NUM_STATES; s++) begin
            st    = viterbi_pkg::state_t'(s);
            // Code pair when coming from the d = 0 predecessor
            pair0 = {st[1] ^ st[0], st[1]};
            cand0 = pm[{st[0], 1'b0}] + viterbi_pkg::path_metric_t'(bm_tab[pair0]);
            cand1 = pm[{st[0], 1'b1}] + viterbi_pkg::path_metric_t'(bm_tab[~pair0]);
            // Tie keeps decision 0
            decisions[s] = (cand1 < cand0);
            // Never underflows, every candidate is at least min_pm
            pm_next[s]   = (decisions[s] ? cand1 : cand0) - min_pm;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pm[0] <= '0;
            for (int s = 1; s < viterbi_pkg::NUM_STATES; s++) begin
                pm[s] <= viterbi_pkg::path_metric_t'(viterbi_pkg::START_METRIC);
            end
        end else if (acs_en) begin
            for (int s = 0; s < viterbi_pkg::NUM_STATES; s++) begin
                pm[s] <= pm_next[s];
            end
        end
    end

endmodule

//--- traceback/survivor_mem.sv
`timescale 1ns/1ns

module survivor_mem (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   acs_en,
    input  viterbi_pkg::decision_t decisions,
    output viterbi_pkg::decision_t history [0:viterbi_pkg::TB_DEPTH-1]
);

    //////////////////////////////////////////////////
    // Decision shift history
    //////////////////////////////////////////////////

    // Entry 0 holds the newest symbol, the last entry the oldest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < viterbi_pkg::TB_DEPTH; i++) begin
                history[i] <= '0;
            end
        end else if (acs_en) begin
            history[0] <= decisions;
            for (int i = 1; i < viterbi_pkg::TB_DEPTH; i++) begin
                history[i] <= history[i-1];
            end
        end
    end

endmodule

//--- traceback/traceback_unit.sv
`timescale 1ns/1ns

module traceback_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tb_en,
    input  viterbi_pkg::state_t    best_state,
    input  viterbi_pkg::decision_t history [0:viterbi_pkg::TB_DEPTH-1],
    output logic                   out_bit
);

    viterbi_pkg::state_t trace_state;

    //////////////////////////////////////////////////
    // Backward walk through the trellis
    //////////////////////////////////////////////////

    // Each step moves to {s[0], d}, d being the stored decision of s
    always_comb begin
        trace_state = best_state;
        for (int i = 0; i < viterbi_pkg::TB_DEPTH - 1; i++) begin
            trace_state = {trace_state[0], history[i][trace_state]};
        end
    end

    // State bit 1 is the information bit of the oldest decoded symbol
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_bit <= 1'b0;
        end else if (tb_en) begin
            out_bit <= trace_state[1];
        end
    end

endmodule

//--- hw/viterbi_ctrl.sv
`timescale 1ns/1ns

module viterbi_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic acs_en,
    output logic tb_en,
    output logic out_valid
);

    viterbi_pkg::ctrl_state_t state;
    viterbi_pkg::warmup_cnt_t warm_cnt;

    // Symbols are dropped only in the single IDLE cycle after reset
    assign acs_en = in_valid && (state != viterbi_pkg::IDLE);

    //////////////////////////////////////////////////
    // Warm-up FSM and strobe pipeline
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= viterbi_pkg::IDLE;
            warm_cnt  <= '0;
            tb_en     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            // Traceback runs the cycle after ACS, out_bit lands one later
            tb_en     <= acs_en && (state == viterbi_pkg::DECODE);
            out_valid <= tb_en;

            case (state)
                viterbi_pkg::IDLE: begin
                    state <= viterbi_pkg::WARMUP;
                end
                viterbi_pkg::WARMUP: begin
                    if (acs_en) begin
                        warm_cnt <= warm_cnt + 1'b1;
                        // Last warm-up symbol, the next one decodes
                        if (warm_cnt == viterbi_pkg::warmup_cnt_t'(viterbi_pkg::WARMUP_LEN - 1)) begin
                            state <= viterbi_pkg::DECODE;
                        end
                    end
                end
                viterbi_pkg::DECODE: begin
                    state <= viterbi_pkg::DECODE;
                end
                default: begin
                    state <= viterbi_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/viterbi_dec.sv
`timescale 1ns/1ns

module viterbi_dec (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  viterbi_pkg::symbol_t in_symbol,
    output logic                 out_valid,
    output logic                 out_bit
);

    logic                          acs_en;
    logic                          tb_en;
    viterbi_pkg::branch_metric_t   bm_00;
    viterbi_pkg::branch_metric_t   bm_01;
    viterbi_pkg::branch_metric_t   bm_10;
    viterbi_pkg::branch_metric_t   bm_11;
    viterbi_pkg::decision_t        decisions;
    viterbi_pkg::state_t           best_state;
    viterbi_pkg::decision_t        history [0:viterbi_pkg::TB_DEPTH-1];

    viterbi_ctrl viterbi_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .acs_en    (acs_en),
        .tb_en     (tb_en),
        .out_valid (out_valid)
    );

    branch_metric branch_metric_inst (
        .in_symbol (in_symbol),
        .bm_00     (bm_00),
        .bm_01     (bm_01),
        .bm_10     (bm_10),
        .bm_11     (bm_11)
    );

    acs_unit acs_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .acs_en     (acs_en),
        .bm_00      (bm_00),
        .bm_01      (bm_01),
        .bm_10      (bm_10),
        .bm_11      (bm_11),
        .decisions  (decisions),
        .best_state (best_state)
    );

    survivor_mem survivor_mem_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .acs_en    (acs_en),
        .decisions (decisions),
        .history   (history)
    );

    traceback_unit traceback_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .tb_en      (tb_en),
        .best_state (best_state),
        .history    (history),
        .out_bit    (out_bit)
    );

endmodule

//--- tb/viterbi_dec_chk.sv
`timescale 1ns/1ns

module viterbi_dec_chk #(
    parameter bit CTRL_SIDE = 1'b0
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      in_valid,
    input logic                      acs_en,
    input logic                      tb_en,
    input logic                      out_valid,
    input viterbi_pkg::path_metric_t pm0,
    input viterbi_pkg::path_metric_t pm1,
    input viterbi_pkg::path_metric_t pm2,
    input viterbi_pkg::path_metric_t pm3
);

    localparam int PM_LIMIT = viterbi_pkg::START_METRIC + 4;

    if (CTRL_SIDE) begin : g_strobes
        // Set by the first traceback strobe after reset
        logic decoding;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                decoding <= 1'b0;
            end else if (tb_en) begin
                decoding <= 1'b1;
            end
        end

        // Each decoded bit answers the symbol two cycles earlier
        out_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> $past(in_valid, 2))
            else $error("out_valid without a symbol two cycles before");

        // Decoding never stops once it has started
        tb_en_follows_acs: assert property (@(posedge clk) disable iff (!rst_n)
            decoding && acs_en |=> tb_en)
            else $error("ACS update while decoding without a traceback strobe");
    end else begin : g_metrics
        // Normalization keeps every metric bounded
        metric_bound: assert property (@(posedge clk) disable iff (!rst_n)
            (pm0 < PM_LIMIT) && (pm1 < PM_LIMIT) && (pm2 < PM_LIMIT) && (pm3 < PM_LIMIT))
            else $error("Path metric reached the normalization bound");
    end

endmodule

bind viterbi_ctrl viterbi_dec_chk #(
    .CTRL_SIDE (1'b1)
) ctrl_chk_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .acs_en    (acs_en),
    .tb_en     (tb_en),
    .out_valid (out_valid),
    .pm0       ('0),
    .pm1       ('0),
    .pm2       ('0),
    .pm3       ('0)
);

bind acs_unit viterbi_dec_chk #(
    .CTRL_SIDE (1'b0)
) acs_chk_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (1'b0),
    .acs_en    (acs_en),
    .tb_en     (1'b0),
    .out_valid (1'b0),
    .pm0       (pm[0]),
    .pm1       (pm[1]),
    .pm2       (pm[2]),
    .pm3       (pm[3])
);

//--- tb/viterbi_dec_tb.sv
`timescale 1ns/1ns

module viterbi_dec_tb;

    localparam int MAX_LINES = 64;
    localparam int DEPTH     = viterbi_pkg::TB_DEPTH;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    viterbi_pkg::symbol_t in_symbol;
    logic                 out_valid;
    logic                 out_bit;

    // One hex digit each: test id, reset flag, info bit, error mask, idle gap
    logic [19:0] patterns [0:MAX_LINES-1];
    // Entries are {test id, information bit}
    logic [4:0]  expected_q [$];
    logic [4:0]  entry;
    logic [1:0]  enc_state;
    logic [2:0]  valid_pipe;
    int          idx_pipe [0:2];
    logic        expect_ov;
    logic [3:0]  cur_test;
    int          sym_count;
    int          bit_errors;
    int          timing_errors;
    int          seed;
    longint      watchdog_ns;

    viterbi_dec viterbi_dec_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_symbol (in_symbol),
        .out_valid (out_valid),
        .out_bit   (out_bit)
    );

    always #10 clk = ~clk;

    // K = 3 encoder, bit 1 from generator 7, bit 0 from generator 5
    function automatic viterbi_pkg::symbol_t encode_pair(input logic u, input logic [1:0] st);
        return {u ^ st[1] ^ st[0], u ^ st[0]};
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "error_free";
            4'd2:    return "single_errors";
            4'd3:    return "warmup";
            4'd4:    return "idle_gaps";
            4'd5:    return "mid_reset";
            default: return "unknown";
        endcase
    endfunction

    // Called and left 2 ns after a rising edge
    task automatic apply_reset();
        rst_n    = 1'b0;
        in_valid = 1'b0;
        expected_q.delete();
        repeat (10) @(posedge clk);
        #2;
        rst_n     = 1'b1;
        enc_state = 2'b00;
        sym_count = 0;
        // Skip the IDLE cycle that follows reset
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic drive_symbol(input logic [3:0] id, input logic u, input logic [1:0] mask,
                                input int idle);
        in_symbol = encode_pair(u, enc_state) ^ mask;
        in_valid  = 1'b1;
        enc_state = {u, enc_state[1]};
        expected_q.push_back({id, u});
        sym_count++;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        for (int i = 0; i < idle; i++) begin
            @(posedge clk);
            #2;
        end
    endtask

    //////////////////////////////////////////////////
    // Output monitor, sampled at the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            valid_pipe = '0;
        end else begin
            valid_pipe  = {valid_pipe[1:0], in_valid};
            idx_pipe[2] = idx_pipe[1];
            idx_pipe[1] = idx_pipe[0];
            idx_pipe[0] = sym_count - 1;
            // Decoded bit is due two cycles after a symbol past warm-up
            expect_ov = valid_pipe[2] && (idx_pipe[2] >= DEPTH - 1);
            check_out_valid: assert (out_valid == expect_ov) else begin
                timing_errors++;
                $display("ERR %s: expected out_valid %0b, actual %0b",
                         test_name(cur_test), expect_ov, out_valid);
            end
            if (out_valid) begin
                check_pending: assert (expected_q.size() > 0) else begin
                    timing_errors++;
                    $display("out_valid came with no decoded bit left to compare");
                end
                if (expected_q.size() > 0) begin
                    entry = expected_q.pop_front();
                    check_bit: assert (out_bit == entry[0]) else begin
                        bit_errors++;
                        $display("ERR %s: expected %0b, actual %0b",
                                 test_name(entry[4:1]), entry[0], out_bit);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int         num_lines;
        int         num_tests;
        int         resets;
        int         max_gap;
        int         extra;
        logic [19:0] word;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_symbol = '0;
        enc_state = 2'b00;
        valid_pipe = '0;
        sym_count = 0;
        bit_errors = 0;
        timing_errors = 0;
        cur_test = 4'd1;
        seed = 32'h7f66_9af3;
        watchdog_ns = 0;
        $readmemh("tb/viterbi_patterns.txt", patterns);

        // Test id F ends the pattern list
        num_lines = 0;
        num_tests = 0;
        resets = 1;
        max_gap = 0;
        while (num_lines < MAX_LINES - 1 && patterns[num_lines][19:16] != 4'hf) begin
            word = patterns[num_lines];
            if (num_lines == 0) begin
                num_tests++;
            end else if (patterns[num_lines-1][19:16] != word[19:16]) begin
                num_tests++;
            end
            resets += int'(word[12]);
            max_gap = (int'(word[3:0]) > max_gap) ? int'(word[3:0]) : max_gap;
            num_lines++;
        end
        watchdog_ns = longint'(num_lines + num_tests * DEPTH) * (max_gap + 3) * 20 * 2
                      + longint'(resets) * 14 * 20;

        apply_reset();
        for (int n = 0; n < num_lines; n++) begin
            word = patterns[n];
            if (word[12]) begin
                apply_reset();
            end
            cur_test = word[19:16];
            // Lines with a gap get 0 to 2 more idle cycles
            extra = (word[3:0] != 4'h0) ? int'($unsigned($random(seed)) % 3) : 0;
            drive_symbol(word[19:16], word[8], word[5:4], int'(word[3:0]) + extra);
            // Zero tail flushes the encoder at the end of each test
            if (patterns[n+1][19:16] != word[19:16]) begin
                repeat (DEPTH) drive_symbol(word[19:16], 1'b0, 2'b00, 0);
            end
        end
        repeat (4) @(posedge clk);

        $display("Errors: %0d bit, %0d timing, %0d total",
                 bit_errors, timing_errors, bit_errors + timing_errors);
        if (bit_errors + timing_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Watchdog expired before all patterns were decoded");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- tb/viterbi_patterns.txt
// Columns, one hex digit each: test id, reset before symbol, info bit, error mask, idle gap
// Test 1 error free, 2 single errors, 3 warm-up, 4 idle gaps, 5 mid-stream reset, F ends
10100
10000
10100
10100
10000
20120
20000
20100
20100
20000
20100
20000
20000
20100
20100
20100
20000
20010
31100
30100
30000
40102
40001
40103
40100
50100
50000
51100
50100
50000
50100
F0000

//--- flist.f
common/viterbi_pkg.sv
hw/branch_metric.sv
acs/acs_unit.sv
traceback/survivor_mem.sv
traceback/traceback_unit.sv
hw/viterbi_ctrl.sv
hw/viterbi_dec.sv
tb/viterbi_dec_chk.sv
tb/viterbi_dec_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing --assert -Wall
TOP       := viterbi_dec_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
